/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
TB_TOP     := pcs_rx_descramble_tb
RTL_TOP    := pcs_rx_descramble_top
FILELIST   := pcs_rx_descramble.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/pcs_rx_descramble_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_descramble_tb;

    import pcs_rx_pkg::*;

    localparam int PAYLOAD_WIDTH = BLOCK_WIDTH - HEADER_WIDTH;
    localparam int HOLD_CYCLES   = 150;
    // the hold window sends at most one block per cycle
    localparam int TOTAL_BLOCKS  = 300 + 50 + 50 + 100 + HOLD_CYCLES + 40;
    localparam int CYCLE_LIMIT   = 4 * TOTAL_BLOCKS + 1000;
    // control header, type 0x1E, eight 7-bit /E/ codes
    localparam logic [BLOCK_WIDTH-1:0] EXPECTED_ERROR = {2'b10, 8'h1E, {8{7'h1E}}};

    logic                   i_clock;
    logic                   i_reset;
    logic                   i_bypass;
    logic                   i_valid;
    logic [BLOCK_WIDTH-1:0] i_data;
    logic                   i_tag;
    logic                   o_credit;
    logic                   i_credit;
    logic                   o_valid;
    logic [BLOCK_WIDTH-1:0] o_data;
    logic                   o_tag;
    logic [COUNT_WIDTH-1:0] o_bad_header_count;

    integer                   seed = 31376;
    int                       cycles;
    int                       sent;
    int                       received;
    int                       credit_pulses;
    int                       tx_credits;
    int                       ds_credits;
    int                       owed;
    int                       model_bad_count;
    logic                     hold_credits;
    logic [SCRAMBLER_LEN-1:0] model_state;
    logic [BLOCK_WIDTH-1:0]   expected_data [$];
    logic                     expected_tag [$];

    pcs_rx_descramble_top i_pcs_rx_descramble_top
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_bypass           (i_bypass),
        .i_valid            (i_valid),
        .i_data             (i_data),
        .i_tag              (i_tag),
        .o_credit           (o_credit),
        .i_credit           (i_credit),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_tag              (o_tag),
        .o_bad_header_count (o_bad_header_count)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        stop_failed();
    endtask

    task automatic check_value(input string name, input logic [BLOCK_WIDTH-1:0] actual,
                               input logic [BLOCK_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_failed();
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // x^58 and x^39 taps are state bits 57 and 38
    // received bits shift in
    task automatic model_block(input logic [BLOCK_WIDTH-1:0] blk, input logic tag);
        logic [BLOCK_WIDTH-1:0] result;
        logic [1:0]             header;
        int                     i;
        result = blk;
        header = blk[BLOCK_WIDTH-1 -: 2];
        if (!i_bypass)
        begin
            for (i = PAYLOAD_WIDTH - 1; i >= 0; i--)
            begin
                result[i]   = blk[i] ^ model_state[57] ^ model_state[38];
                model_state = {model_state[56:0], blk[i]};
            end
        end
        if (header == 2'b00 || header == 2'b11)
        begin
            result = EXPECTED_ERROR;
            model_bad_count++;
        end
        expected_data.push_back(result);
        expected_tag.push_back(tag);
    endtask

    task automatic take_output();
        if (ds_credits == 0)
            abort_run("o_valid pulsed with no downstream credit outstanding");
        else if (expected_data.size() == 0)
            abort_run("an output block arrived with none expected");
        else
        begin
            ds_credits--;
            owed++;
            received++;
            check_value("o_data", o_data, expected_data.pop_front());
            check_value("o_tag", o_tag, expected_tag.pop_front());
        end
    endtask

    // one clock with outputs sampled after the edge and idle inputs driven
    task automatic tick();
        @(posedge i_clock);
        #10;
        if (o_credit)
        begin
            credit_pulses++;
            tx_credits++;
        end
        if (credit_pulses > sent)
            abort_run("the ingress returned more credits than blocks were sent");
        if (o_valid)
            take_output();
        i_valid  = 1'b0;
        i_credit = 1'b0;
        if (!hold_credits && owed > 0 && next_random() % 4 != 0)
        begin
            i_credit = 1'b1;
            owed--;
            ds_credits++;
        end
    endtask

    task automatic try_send(input logic bad_mix);
        logic [31:0]            rnd;
        logic [1:0]             header;
        logic [BLOCK_WIDTH-1:0] blk;
        rnd = next_random();
        if (tx_credits > 0 && rnd[1:0] != 2'b00)
        begin
            header = rnd[3:2];
            if (!bad_mix)
                header = rnd[4] ? 2'b01 : 2'b10;
            blk     = {header, next_random(), next_random()};
            i_valid = 1'b1;
            i_data  = blk;
            i_tag   = rnd[5];
            model_block(blk, rnd[5]);
            tx_credits--;
            sent++;
        end
    endtask

    task automatic send_blocks(input int count, input logic bad_mix);
        int target;
        target = sent + count;
        while (sent < target)
        begin
            tick();
            try_send(bad_mix);
        end
    endtask

    task automatic drain();
        while (received < sent)
            tick();
    endtask

    task automatic check_reset_outputs();
        check_value("o_valid", o_valid, 0);
        check_value("o_credit", o_credit, 0);
        check_value("o_bad_header_count", o_bad_header_count, 0);
    endtask

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge i_clock);
            cycles++;
            if (cycles >= CYCLE_LIMIT)
                abort_run($sformatf("timeout after %0d cycles, %0d of %0d blocks received",
                                    cycles, received, sent));
        end
    end

    initial
    begin
        i_reset         = 1'b1;
        i_bypass        = 1'b0;
        i_valid         = 1'b0;
        i_data          = '0;
        i_tag           = 1'b0;
        i_credit        = 1'b0;
        sent            = 0;
        received        = 0;
        credit_pulses   = 0;
        tx_credits      = INGRESS_DEPTH;
        ds_credits      = EGRESS_DEPTH;
        owed            = 0;
        model_bad_count = 0;
        hold_credits    = 1'b0;
        model_state     = '0;
        repeat (2)
        begin
            @(posedge i_clock);
            #10;
            check_reset_outputs();
        end
        i_reset = 1'b0;
        @(posedge i_clock);
        #10;
        check_reset_outputs();

        send_blocks(300, 1'b0);
        drain();
        // bypass only with the pipeline empty
        i_bypass = 1'b1;
        send_blocks(50, 1'b0);
        drain();
        i_bypass = 1'b0;
        send_blocks(50, 1'b0);
        send_blocks(100, 1'b1);

        // downstream holds every credit back
        hold_credits = 1'b1;
        repeat (HOLD_CYCLES)
        begin
            tick();
            try_send(1'b1);
        end
        if (received >= sent)
            abort_run("the pipeline did not back up while credits were withheld");
        hold_credits = 1'b0;
        send_blocks(40, 1'b1);
        drain();
        repeat (4) tick();

        check_value("o_bad_header_count", o_bad_header_count, model_bad_count);
        check_value("o_credit pulse total", credit_pulses, sent);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/descrambler.sv */
`timescale 1ns/1ps
`default_nettype none

module descrambler
(
    input  wire logic               i_clock,
    input  wire logic               i_reset,
    input  wire logic               i_enable,
    input  wire logic               i_bypass,
    input  wire logic               i_valid,
    input  wire pcs_rx_pkg::block_t i_data,
    input  wire logic               i_tag,
    output logic                    o_valid,
    output pcs_rx_pkg::block_t      o_data,
    output logic                    o_tag
);

    import pcs_rx_pkg::*;

    scrambler_state_t state;
    scrambler_state_t state_next;
    block_t           descrambled;
    logic             advance_state;

    // payload runs msb first, right below the sync header
    always_comb
    begin
        state_next  = state;
        descrambled = i_data;
        for (int i = BLOCK_WIDTH - HEADER_WIDTH - 1; i >= 0; i--)
        begin
            descrambled[i] = i_data[i]
                           ^ state_next[SCRAMBLER_LEN-1]
                           ^ state_next[SCRAMBLER_TAP-1];
            // received (scrambled) bit feeds the state
            state_next = {state_next[SCRAMBLER_LEN-2:0], i_data[i]};
        end
    end

    assign advance_state = i_enable && i_valid && !i_bypass;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= SCRAMBLER_SEED;
        else if (advance_state)
            state <= state_next;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else if (i_enable)
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable && i_valid)
        begin
            // bypass passes the block as received
            o_data <= i_bypass ? i_data : descrambled;
            o_tag  <= i_tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/pcs_rx_descramble_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_descramble_top
(
    input  wire logic               i_clock,
    input  wire logic               i_reset,
    input  wire logic               i_bypass,
    input  wire logic               i_valid,
    input  wire pcs_rx_pkg::block_t i_data,
    input  wire logic               i_tag,
    output logic                    o_credit,
    input  wire logic               i_credit,
    output logic                    o_valid,
    output pcs_rx_pkg::block_t      o_data,
    output logic                    o_tag,
    output pcs_rx_pkg::count_t      o_bad_header_count
);

    logic               s_advance;
    logic               ingress_valid;
    pcs_rx_pkg::block_t ingress_data;
    logic               ingress_tag;
    logic               descr_valid;
    pcs_rx_pkg::block_t descr_data;
    logic               descr_tag;
    logic               check_valid;
    pcs_rx_pkg::block_t check_data;
    logic               check_tag;
    logic               egress_push;

    // frozen checker output must not be pushed twice
    assign egress_push = check_valid && s_advance;

    rx_block_ingress u_rx_block_ingress
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_data    (i_data),
        .i_tag     (i_tag),
        .i_advance (s_advance),
        .o_credit  (o_credit),
        .o_valid   (ingress_valid),
        .o_data    (ingress_data),
        .o_tag     (ingress_tag)
    );

    descrambler u_descrambler
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (s_advance),
        .i_bypass (i_bypass),
        .i_valid  (ingress_valid),
        .i_data   (ingress_data),
        .i_tag    (ingress_tag),
        .o_valid  (descr_valid),
        .o_data   (descr_data),
        .o_tag    (descr_tag)
    );

    sync_header_checker u_sync_header_checker
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_enable           (s_advance),
        .i_valid            (descr_valid),
        .i_data             (descr_data),
        .i_tag              (descr_tag),
        .o_valid            (check_valid),
        .o_data             (check_data),
        .o_tag              (check_tag),
        .o_bad_header_count (o_bad_header_count)
    );

    rx_block_egress u_rx_block_egress
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (egress_push),
        .i_data    (check_data),
        .i_tag     (check_tag),
        .i_credit  (i_credit),
        .o_advance (s_advance),
        .o_valid   (o_valid),
        .o_data    (o_data),
        .o_tag     (o_tag)
    );

endmodule

`default_nettype wire

/* hdl/pcs_rx_pkg.sv */
`default_nettype none

package pcs_rx_pkg;

    // 64b/66b coded block geometry
    localparam int BLOCK_WIDTH  = 66;
    localparam int HEADER_WIDTH = 2;

    // self-synchronizing descrambler, 1 + x^39 + x^58
    localparam int SCRAMBLER_LEN = 58;
    localparam int SCRAMBLER_TAP = 39;

    // buffer depths on both sides
    localparam int INGRESS_DEPTH = 4;
    localparam int EGRESS_DEPTH  = 4;

    // credit counter holds 0 .. 4
    localparam int CREDIT_WIDTH = 3;

    // bad header counter width
    localparam int COUNT_WIDTH = 16;

    typedef logic [BLOCK_WIDTH-1:0]   block_t;
    typedef logic [HEADER_WIDTH-1:0]  header_t;
    typedef logic [SCRAMBLER_LEN-1:0] scrambler_state_t;
    typedef logic [CREDIT_WIDTH-1:0]  credit_t;
    typedef logic [COUNT_WIDTH-1:0]   count_t;

    localparam scrambler_state_t SCRAMBLER_SEED = '0;

    // valid sync headers
    localparam header_t SH_DATA = 2'b01;
    localparam header_t SH_CTRL = 2'b10;

    // control block, type 0x1E, eight /E/ codes
    localparam block_t ERROR_BLOCK = {
        SH_CTRL,
        8'h1E,
        {8{7'h1E}}
    };

endpackage

`default_nettype wire

/* hdl/rx_block_egress.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_block_egress
(
    input  wire logic               i_clock,
    input  wire logic               i_reset,
    input  wire logic               i_valid,
    input  wire pcs_rx_pkg::block_t i_data,
    input  wire logic               i_tag,
    input  wire logic               i_credit,
    output logic                    o_advance,
    output logic                    o_valid,
    output pcs_rx_pkg::block_t      o_data,
    output logic                    o_tag
);

    import pcs_rx_pkg::*;

    block_t                          data_mem [EGRESS_DEPTH];
    logic                            tag_mem  [EGRESS_DEPTH];
    logic [$clog2(EGRESS_DEPTH)-1:0] wr_ptr;
    logic [$clog2(EGRESS_DEPTH)-1:0] rd_ptr;
    credit_t                         fill;
    credit_t                         credits;
    logic                            empty;
    logic                            pop;

    assign empty     = (fill == '0);
    assign o_advance = (fill != credit_t'(EGRESS_DEPTH));

    // an empty FIFO hands the incoming block straight to the output
    assign pop = (credits != '0) && (!empty || i_valid);

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            data_mem[wr_ptr] <= i_data;
            tag_mem[wr_ptr]  <= i_tag;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= credit_t'(EGRESS_DEPTH);
            o_valid <= 1'b0;
        end
        else
        begin
            if (i_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({i_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // send and credit return may coincide
            case ({pop, i_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            o_valid <= pop;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (pop)
        begin
            o_data <= empty ? i_data : data_mem[rd_ptr];
            o_tag  <= empty ? i_tag : tag_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/rx_block_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_block_ingress
(
    input  wire logic              i_clock,
    input  wire logic              i_reset,
    input  wire logic              i_valid,
    input  wire pcs_rx_pkg::block_t i_data,
    input  wire logic              i_tag,
    input  wire logic              i_advance,
    output logic                   o_credit,
    output logic                   o_valid,
    output pcs_rx_pkg::block_t     o_data,
    output logic                   o_tag
);

    import pcs_rx_pkg::*;

    block_t                               data_mem [INGRESS_DEPTH];
    logic                                 tag_mem  [INGRESS_DEPTH];
    logic [$clog2(INGRESS_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(INGRESS_DEPTH)-1:0]     rd_ptr;
    credit_t                              fill;
    logic                                 empty;
    logic                                 full;
    logic                                 push;
    logic                                 pop;

    assign empty = (fill == '0);
    assign full  = (fill == credit_t'(INGRESS_DEPTH));

    // sender only transmits while holding a credit, so full never blocks in practice
    assign push = i_valid && !full;
    assign pop  = i_advance && !empty;

    always_ff @(posedge i_clock)
    begin
        if (push)
        begin
            data_mem[wr_ptr] <= i_data;
            tag_mem[wr_ptr]  <= i_tag;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            o_valid  <= 1'b0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // one credit back per block issued
            o_credit <= pop;
            if (i_advance)
                o_valid <= pop;
        end
    end

    // head register, held while stalled
    always_ff @(posedge i_clock)
    begin
        if (pop)
        begin
            o_data <= data_mem[rd_ptr];
            o_tag  <= tag_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/sync_header_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_header_checker
(
    input  wire logic               i_clock,
    input  wire logic               i_reset,
    input  wire logic               i_enable,
    input  wire logic               i_valid,
    input  wire pcs_rx_pkg::block_t i_data,
    input  wire logic               i_tag,
    output logic                    o_valid,
    output pcs_rx_pkg::block_t      o_data,
    output logic                    o_tag,
    output pcs_rx_pkg::count_t      o_bad_header_count
);

    import pcs_rx_pkg::*;

    header_t header;
    logic    header_bad;
    logic    take;

    assign header     = i_data[BLOCK_WIDTH-1 -: HEADER_WIDTH];
    assign header_bad = (header != SH_DATA) && (header != SH_CTRL);
    assign take       = i_enable && i_valid;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else if (i_enable)
            o_valid <= i_valid;
    end

    // 00 and 11 headers become an error control block, tag kept
    always_ff @(posedge i_clock)
    begin
        if (take)
        begin
            o_data <= header_bad ? ERROR_BLOCK : i_data;
            o_tag  <= i_tag;
        end
    end

    // saturating bad header counter
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_bad_header_count <= '0;
        else if (take && header_bad && (o_bad_header_count != '1))
            o_bad_header_count <= o_bad_header_count + 1'b1;
    end

endmodule

`default_nettype wire

/* pcs_rx_descramble.f */
hdl/pcs_rx_pkg.sv
hdl/rx_block_ingress.sv
hdl/descrambler.sv
hdl/sync_header_checker.sv
hdl/rx_block_egress.sv
hdl/pcs_rx_descramble_top.sv
dv/pcs_rx_descramble_tb.sv
